// ==== Bender.yml ====
package:
  name: blueprint_sprite_video

sources:
  - include_dirs:
      - source
    files:
      - source/blueprint_video_pkg.sv
      - source/video_timing.sv
      - source/sprite_store.sv
      - source/sprite_scan_ctrl.sv
      - source/sprite_line_buffer.sv
      - source/blueprint_sprite_video.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/blueprint_sprite_video_assertions.sv
      - verif/tb_blueprint_sprite_video.sv

// ==== compile.f ====
+incdir+source
source/blueprint_video_pkg.sv
source/video_timing.sv
source/sprite_store.sv
source/sprite_scan_ctrl.sv
source/sprite_line_buffer.sv
source/blueprint_sprite_video.sv
verif/blueprint_sprite_video_assertions.sv
verif/tb_blueprint_sprite_video.sv

// ==== source/blueprint_sprite_video.sv ====
`timescale 1ns/1ps
`default_nettype none

module blueprint_sprite_video (
	input  wire                                 clk_49m,
	input  wire                                 reset,
	input  wire  blueprint_video_pkg::center_t  h_center_i,
	input  wire  blueprint_video_pkg::center_t  v_center_i,
	input  wire  blueprint_video_pkg::host_wr_t host_wr_i,
	input  wire                                 host_valid_i,
	output logic                                host_ready_o,
	output blueprint_video_pkg::rgb_t           rgb_o,
	output logic                                hblank_o,
	output logic                                vblank_o,
	output logic                                hsync_o,
	output logic                                vsync_o,
	output logic                                csync_o,
	output logic                                ce_pix_o
);

	import blueprint_video_pkg::*;

	// Raster timing
	logic          pix_en;
	raster_h_t     h_pos;
	raster_v_t     v_pos;
	logic          hblank;
	logic          vblank;
	logic          hsync;
	logic          vsync;

	// Scanner to memories
	logic          scan_busy;
	spr_ram_addr_t attr_addr;
	byte_t         attr_data;
	pattern_addr_t pat_addr;
	pattern_rd_t   pat_data;

	// Scanner to line buffer
	logic          lb_wr_en;
	byte_t         lb_wr_addr;
	spr_pixel_t    lb_wr_pixel;

	video_timing u_timing (
		.clk_49m    (clk_49m),
		.reset      (reset),
		.h_center_i (h_center_i),
		.v_center_i (v_center_i),
		.pix_en_o   (pix_en),
		.h_pos_o    (h_pos),
		.v_pos_o    (v_pos),
		.hblank_o   (hblank),
		.vblank_o   (vblank),
		.hsync_o    (hsync),
		.vsync_o    (vsync)
	);

	sprite_store u_store (
		.clk_49m      (clk_49m),
		.reset        (reset),
		.host_wr_i    (host_wr_i),
		.host_valid_i (host_valid_i),
		.host_ready_o (host_ready_o),
		.scan_busy_i  (scan_busy),
		.attr_addr_i  (attr_addr),
		.attr_data_o  (attr_data),
		.pat_addr_i   (pat_addr),
		.pat_data_o   (pat_data)
	);

	sprite_scan_ctrl u_scan (
		.clk_49m       (clk_49m),
		.reset         (reset),
		.pix_en_i      (pix_en),
		.h_pos_i       (h_pos),
		.v_pos_i       (v_pos),
		.scan_busy_o   (scan_busy),
		.attr_addr_o   (attr_addr),
		.attr_data_i   (attr_data),
		.pat_addr_o    (pat_addr),
		.pat_data_i    (pat_data),
		.lb_wr_en_o    (lb_wr_en),
		.lb_wr_addr_o  (lb_wr_addr),
		.lb_wr_pixel_o (lb_wr_pixel)
	);

	sprite_line_buffer u_line_buf (
		.clk_49m       (clk_49m),
		.reset         (reset),
		.pix_en_i      (pix_en),
		.h_pos_i       (h_pos),
		.hblank_i      (hblank),
		.vblank_i      (vblank),
		.hsync_i       (hsync),
		.vsync_i       (vsync),
		.lb_wr_en_i    (lb_wr_en),
		.lb_wr_addr_i  (lb_wr_addr),
		.lb_wr_pixel_i (lb_wr_pixel),
		.rgb_o         (rgb_o),
		.hblank_o      (hblank_o),
		.vblank_o      (vblank_o),
		.hsync_o       (hsync_o),
		.vsync_o       (vsync_o),
		.csync_o       (csync_o)
	);

	// Pixel enable for the downstream scaler
	assign ce_pix_o = pix_en;

endmodule

`default_nettype wire

// ==== source/blueprint_video_defs.svh ====
`ifndef BLUEPRINT_VIDEO_DEFS_SVH
`define BLUEPRINT_VIDEO_DEFS_SVH

// ===================================================================
// Raster geometry
// ===================================================================

// Full raster including blanking
`define BPV_H_TOTAL      320
`define BPV_V_TOTAL      264

// First column of horizontal blanking
`define BPV_H_ACTIVE     256

// Visible line range
`define BPV_V_ACT_START  16
`define BPV_V_ACT_END    240

// Sync pulses before the centering offset is added
`define BPV_HS_BASE      280
`define BPV_HS_WIDTH     32
`define BPV_VS_BASE      248
`define BPV_VS_WIDTH     4

// Pixel enable ratio against clk_49m
`define BPV_CEN_NUM      89
`define BPV_CEN_DEN      875

// ===================================================================
// Sprite hardware
// ===================================================================

`define BPV_SPR_COUNT    64
`define BPV_SPR_HEIGHT   16
// Bias used by the line match of the scanner
`define BPV_SPR_Y_BIAS   239
`define BPV_SPR_X_BIAS   2

// Level of a lit colour channel
`define BPV_LEVEL_ON     31

`endif

// ==== source/blueprint_video_pkg.sv ====
`default_nettype none

package blueprint_video_pkg;

	// Raster positions
	typedef logic [8:0]  raster_h_t;
	typedef logic [8:0]  raster_v_t;
	typedef logic [3:0]  center_t;

	// Memory addressing and data
	typedef logic [7:0]  spr_ram_addr_t;
	// Pattern address is {code, line in sprite}
	typedef logic [11:0] pattern_addr_t;
	typedef logic [7:0]  byte_t;

	// Sprite pixel bit0 R, bit1 B, bit2 G
	// Zero marks a transparent pixel
	typedef logic [2:0]  spr_pixel_t;
	typedef logic [4:0]  colour_t;

	// Destination of a host write
	typedef enum logic [1:0] {
		SPRITE_RAM,
		PLANE_R,
		PLANE_B,
		PLANE_G
	} store_target_e;

	// Only addr[7:0] counts for the sprite RAM
	typedef struct packed {
		store_target_e target;
		pattern_addr_t addr;
		byte_t         data;
	} host_wr_t;

	typedef struct packed {
		colour_t red;
		colour_t green;
		colour_t blue;
	} rgb_t;

	// One byte per pattern plane
	typedef struct packed {
		byte_t r;
		byte_t b;
		byte_t g;
	} pattern_rd_t;

	typedef enum logic [3:0] {
		IDLE,
		INIT_RD,
		INIT_LAT,
		RD_B0,
		RD_B1,
		RD_B2,
		RD_B3,
		ROMADDR,
		ROMWAIT,
		PIXELS,
		NEXT
	} spr_state_e;

endpackage

`default_nettype wire

// ==== source/sprite_line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blueprint_video_defs.svh"

module sprite_line_buffer (
	input  wire                                   clk_49m,
	input  wire                                   reset,
	input  wire                                   pix_en_i,
	input  wire  blueprint_video_pkg::raster_h_t  h_pos_i,
	input  wire                                   hblank_i,
	input  wire                                   vblank_i,
	input  wire                                   hsync_i,
	input  wire                                   vsync_i,
	input  wire                                   lb_wr_en_i,
	input  wire  blueprint_video_pkg::byte_t      lb_wr_addr_i,
	input  wire  blueprint_video_pkg::spr_pixel_t lb_wr_pixel_i,
	output blueprint_video_pkg::rgb_t             rgb_o,
	output logic                                  hblank_o,
	output logic                                  vblank_o,
	output logic                                  hsync_o,
	output logic                                  vsync_o,
	output logic                                  csync_o
);

	import blueprint_video_pkg::*;

	// Two banks, one shown while the other is drawn
	spr_pixel_t bank_mem [0:1][0:255];
	logic       bank_sel;
	logic       disp_sel;
	logic       clear_en;
	byte_t      rd_addr;
	spr_pixel_t rd_pixel;
	rgb_t       rgb_exp;

	// Column 0 already reads the bank that the swap is about to select
	assign disp_sel = (h_pos_i == '0) ? ~bank_sel : bank_sel;
	assign rd_addr  = h_pos_i[7:0];
	assign rd_pixel = bank_mem[disp_sel][rd_addr];
	assign clear_en = pix_en_i && !hblank_i;

	always_ff @(posedge clk_49m) begin
		if (!reset)
			bank_sel <= 1'b0;
		else if (pix_en_i && h_pos_i == '0)
			bank_sel <= ~bank_sel;
	end

	// ===================================================================
	// Bank write ports
	// ===================================================================

	// Display side clears each entry as it goes out
	// Scanner writes only during hblank, so the two never meet
	for (genvar b = 0; b < 2; b++) begin : g_bank
		always_ff @(posedge clk_49m) begin
			if (clear_en && disp_sel == 1'(b))
				bank_mem[b][rd_addr] <= '0;
			else if (lb_wr_en_i && bank_sel != 1'(b))
				bank_mem[b][lb_wr_addr_i] <= lb_wr_pixel_i;
		end
	end

	// ===================================================================
	// Colour expansion and output stage
	// ===================================================================

	assign rgb_exp.red   = rd_pixel[0] ? 5'(`BPV_LEVEL_ON) : 5'd0;
	assign rgb_exp.blue  = rd_pixel[1] ? 5'(`BPV_LEVEL_ON) : 5'd0;
	assign rgb_exp.green = rd_pixel[2] ? 5'(`BPV_LEVEL_ON) : 5'd0;

	// Pixel and timing flags share one register stage
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			rgb_o    <= '0;
			hblank_o <= 1'b1;
			vblank_o <= 1'b1;
			hsync_o  <= 1'b0;
			vsync_o  <= 1'b0;
		end else if (pix_en_i) begin
			rgb_o    <= (hblank_i || vblank_i) ? '0 : rgb_exp;
			hblank_o <= hblank_i;
			vblank_o <= vblank_i;
			hsync_o  <= hsync_i;
			vsync_o  <= vsync_i;
		end
	end

	// Composite sync is low while exactly one sync is active
	assign csync_o = ~(hsync_o ^ vsync_o);

endmodule

`default_nettype wire

// ==== source/sprite_scan_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blueprint_video_defs.svh"

module sprite_scan_ctrl (
	input  wire                                      clk_49m,
	input  wire                                      reset,
	input  wire                                      pix_en_i,
	input  wire  blueprint_video_pkg::raster_h_t     h_pos_i,
	input  wire  blueprint_video_pkg::raster_v_t     v_pos_i,
	output logic                                     scan_busy_o,
	output blueprint_video_pkg::spr_ram_addr_t       attr_addr_o,
	input  wire  blueprint_video_pkg::byte_t         attr_data_i,
	output blueprint_video_pkg::pattern_addr_t       pat_addr_o,
	input  wire  blueprint_video_pkg::pattern_rd_t   pat_data_i,
	output logic                                     lb_wr_en_o,
	output blueprint_video_pkg::byte_t               lb_wr_addr_o,
	output blueprint_video_pkg::spr_pixel_t          lb_wr_pixel_o
);

	import blueprint_video_pkg::*;

	spr_state_e    state;
	logic [5:0]    spr_idx;
	byte_t         next_line;
	// Attribute bytes of the current sprite
	byte_t         spr_y;
	byte_t         spr_code;
	byte_t         spr_flags;
	byte_t         spr_x;
	// Y-flip of this sprite and the one carried to the next
	logic          spr_flipy;
	logic          carry_flipy;
	logic [2:0]    pix_cnt;
	spr_ram_addr_t attr_addr_q;
	pattern_addr_t pat_addr_q;

	logic [8:0]    line_raw;
	logic          line_hit;
	logic [3:0]    line_sel;
	logic [2:0]    bit_pos;
	spr_pixel_t    pix_val;

	// ===================================================================
	// Line match and pixel select
	// ===================================================================

	// Row inside the sprite, biased as the original board does
	assign line_raw = {1'b0, next_line} - 9'(`BPV_SPR_Y_BIAS) + {1'b0, spr_y};
	assign line_hit = (line_raw < 9'(`BPV_SPR_HEIGHT));
	assign line_sel = spr_flipy ? 4'(`BPV_SPR_HEIGHT - 1) - line_raw[3:0] : line_raw[3:0];

	// Flags bit 6 sends bit 0 out first
	assign bit_pos = spr_flags[6] ? pix_cnt : 3'd7 - pix_cnt;
	assign pix_val = {pat_data_i.g[bit_pos], pat_data_i.b[bit_pos], pat_data_i.r[bit_pos]};

	// Transparent pixels leave the line buffer alone
	assign lb_wr_en_o    = (state == PIXELS) && (pix_val != '0);
	assign lb_wr_addr_o  = spr_x + 8'(pix_cnt) + 8'(`BPV_SPR_X_BIAS);
	assign lb_wr_pixel_o = pix_val;

	assign scan_busy_o = (state != IDLE);
	assign attr_addr_o = attr_addr_q;
	assign pat_addr_o  = pat_addr_q;

	// ===================================================================
	// Scanner FSM
	// ===================================================================

	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			state       <= IDLE;
			spr_idx     <= '0;
			carry_flipy <= 1'b0;
			pix_cnt     <= '0;
			attr_addr_q <= '0;
			pat_addr_q  <= '0;
		end else begin
			case (state)
				IDLE: begin
					// Start of hblank, prepare the next line
					if (pix_en_i && h_pos_i == 9'(`BPV_H_ACTIVE)) begin
						next_line   <= 8'(v_pos_i + 9'd1);
						// Flags byte of the last sprite
						attr_addr_q <= {6'(`BPV_SPR_COUNT - 1), 2'd2};
						state       <= INIT_RD;
					end
				end
				INIT_RD: begin
					state <= INIT_LAT;
				end
				INIT_LAT: begin
					// Sprite 0 inherits Y-flip from the last sprite
					carry_flipy <= attr_data_i[7];
					spr_idx     <= '0;
					attr_addr_q <= '0;
					state       <= RD_B0;
				end
				RD_B0: begin
					attr_addr_q <= {spr_idx, 2'd1};
					state       <= RD_B1;
				end
				RD_B1: begin
					spr_y       <= attr_data_i;
					attr_addr_q <= {spr_idx, 2'd2};
					state       <= RD_B2;
				end
				RD_B2: begin
					spr_code    <= attr_data_i;
					attr_addr_q <= {spr_idx, 2'd3};
					state       <= RD_B3;
				end
				RD_B3: begin
					spr_flags <= attr_data_i;
					spr_flipy <= carry_flipy;
					state     <= ROMADDR;
				end
				ROMADDR: begin
					spr_x       <= attr_data_i;
					// This sprite's bit 7 flips the next one
					carry_flipy <= spr_flags[7];
					if (line_hit) begin
						pat_addr_q <= {spr_code, line_sel};
						state      <= ROMWAIT;
					end else begin
						state <= NEXT;
					end
				end
				ROMWAIT: begin
					// Plane bytes arrive for the first pixel
					pix_cnt <= '0;
					state   <= PIXELS;
				end
				PIXELS: begin
					if (pix_cnt == 3'd7)
						state <= NEXT;
					else
						pix_cnt <= pix_cnt + 3'd1;
				end
				NEXT: begin
					if (spr_idx == 6'(`BPV_SPR_COUNT - 1)) begin
						state <= IDLE;
					end else begin
						spr_idx     <= spr_idx + 6'd1;
						attr_addr_q <= {spr_idx + 6'd1, 2'd0};
						state       <= RD_B0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/sprite_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_store (
	input  wire                                      clk_49m,
	input  wire                                      reset,
	input  wire  blueprint_video_pkg::host_wr_t      host_wr_i,
	input  wire                                      host_valid_i,
	output logic                                     host_ready_o,
	input  wire                                      scan_busy_i,
	input  wire  blueprint_video_pkg::spr_ram_addr_t attr_addr_i,
	output blueprint_video_pkg::byte_t               attr_data_o,
	input  wire  blueprint_video_pkg::pattern_addr_t pat_addr_i,
	output blueprint_video_pkg::pattern_rd_t         pat_data_o
);

	import blueprint_video_pkg::*;

	// Sprite attributes, 64 entries of four bytes
	byte_t attr_mem [0:255];
	// Pattern planes addressed by {code, line}
	byte_t plane_r  [0:4095];
	byte_t plane_b  [0:4095];
	byte_t plane_g  [0:4095];

	logic wr_fire;

	// Memories are owned by the scanner for the whole scan
	assign host_ready_o = ~scan_busy_i;
	assign wr_fire      = host_valid_i && host_ready_o;

	// ===================================================================
	// Host write port
	// ===================================================================

	always_ff @(posedge clk_49m) begin
		if (wr_fire) begin
			case (host_wr_i.target)
				SPRITE_RAM: attr_mem[host_wr_i.addr[7:0]] <= host_wr_i.data;
				PLANE_R:    plane_r[host_wr_i.addr]       <= host_wr_i.data;
				PLANE_B:    plane_b[host_wr_i.addr]       <= host_wr_i.data;
				PLANE_G:    plane_g[host_wr_i.addr]       <= host_wr_i.data;
				default: ;
			endcase
		end
	end

	// ===================================================================
	// Scanner read ports
	// ===================================================================

	// One clock of latency on both ports
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			attr_data_o <= '0;
			pat_data_o  <= '0;
		end else begin
			attr_data_o  <= attr_mem[attr_addr_i];
			pat_data_o.r <= plane_r[pat_addr_i];
			pat_data_o.b <= plane_b[pat_addr_i];
			pat_data_o.g <= plane_g[pat_addr_i];
		end
	end

endmodule

`default_nettype wire

// ==== source/video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blueprint_video_defs.svh"

module video_timing (
	input  wire                                clk_49m,
	input  wire                                reset,
	input  wire  blueprint_video_pkg::center_t h_center_i,
	input  wire  blueprint_video_pkg::center_t v_center_i,
	output logic                               pix_en_o,
	output blueprint_video_pkg::raster_h_t     h_pos_o,
	output blueprint_video_pkg::raster_v_t     v_pos_o,
	output logic                               hblank_o,
	output logic                               vblank_o,
	output logic                               hsync_o,
	output logic                               vsync_o
);

	import blueprint_video_pkg::*;

	logic [9:0]  cen_acc;
	logic [10:0] cen_sum;
	logic        pix_en_q;
	raster_h_t   h_cnt;
	raster_v_t   v_cnt;
	raster_h_t   hs_start;
	raster_v_t   vs_start;

	// ===================================================================
	// Fractional pixel enable
	// ===================================================================

	// Accumulator adds NUM each clock and fires when it passes DEN
	// Ratio is below one half so two pulses never touch
	assign cen_sum = {1'b0, cen_acc} + 11'(`BPV_CEN_NUM);

	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			cen_acc  <= '0;
			pix_en_q <= 1'b0;
		end else if (cen_sum >= 11'(`BPV_CEN_DEN)) begin
			cen_acc  <= 10'(cen_sum - 11'(`BPV_CEN_DEN));
			pix_en_q <= 1'b1;
		end else begin
			cen_acc  <= cen_sum[9:0];
			pix_en_q <= 1'b0;
		end
	end

	// ===================================================================
	// Raster counters
	// ===================================================================

	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (pix_en_q) begin
			if (h_cnt == 9'(`BPV_H_TOTAL - 1)) begin
				h_cnt <= '0;
				// Line wrap at the bottom of the frame
				if (v_cnt == 9'(`BPV_V_TOTAL - 1))
					v_cnt <= '0;
				else
					v_cnt <= v_cnt + 9'd1;
			end else begin
				h_cnt <= h_cnt + 9'd1;
			end
		end
	end

	// Blanking straight from the counters
	assign hblank_o = (h_cnt >= 9'(`BPV_H_ACTIVE));
	assign vblank_o = (v_cnt < 9'(`BPV_V_ACT_START)) || (v_cnt >= 9'(`BPV_V_ACT_END));

	// Sync windows shifted by the centering inputs
	// A large offset clips the pulse at the end of the line or frame
	assign hs_start = 9'(`BPV_HS_BASE) + {5'd0, h_center_i};
	assign vs_start = 9'(`BPV_VS_BASE) + {5'd0, v_center_i};
	assign hsync_o  = (h_cnt >= hs_start) && (h_cnt < hs_start + 9'(`BPV_HS_WIDTH));
	assign vsync_o  = (v_cnt >= vs_start) && (v_cnt < vs_start + 9'(`BPV_VS_WIDTH));

	assign pix_en_o = pix_en_q;
	assign h_pos_o  = h_cnt;
	assign v_pos_o  = v_cnt;

endmodule

`default_nettype wire

// ==== verif/blueprint_sprite_video_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module blueprint_sprite_video_assertions (
	input wire                                 clk_49m,
	input wire                                 reset,
	input wire  blueprint_video_pkg::rgb_t     rgb_o,
	input wire                                 hblank_o,
	input wire                                 vblank_o,
	input wire                                 hsync_o,
	input wire                                 vsync_o,
	input wire                                 csync_o,
	input wire  blueprint_video_pkg::host_wr_t host_wr_i,
	input wire                                 host_valid_i,
	input wire                                 host_ready_o
);

	import blueprint_video_pkg::*;

	// Blanked output is always black
	a_black_in_blank: assert property (@(posedge clk_49m) disable iff (!reset)
		(hblank_o || vblank_o) |-> (rgb_o == '0))
		else $error("rgb_o not black during blanking");

	// Composite sync from the two registered syncs
	a_csync_xnor: assert property (@(posedge clk_49m) disable iff (!reset)
		csync_o == ~(hsync_o ^ vsync_o))
		else $error("csync_o does not match hsync_o and vsync_o");

	// Host keeps its write steady while stalled
	a_host_hold: assert property (@(posedge clk_49m) disable iff (!reset)
		(host_valid_i && !host_ready_o) |=> (host_valid_i && $stable(host_wr_i)))
		else $error("host write changed while stalled");

endmodule

bind blueprint_sprite_video blueprint_sprite_video_assertions u_assertions (
	.clk_49m      (clk_49m),
	.reset        (reset),
	.rgb_o        (rgb_o),
	.hblank_o     (hblank_o),
	.vblank_o     (vblank_o),
	.hsync_o      (hsync_o),
	.vsync_o      (vsync_o),
	.csync_o      (csync_o),
	.host_wr_i    (host_wr_i),
	.host_valid_i (host_valid_i),
	.host_ready_o (host_ready_o)
);

`default_nettype wire

// ==== verif/tb_blueprint_sprite_video.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "blueprint_video_defs.svh"

module tb_blueprint_sprite_video;

	import blueprint_video_pkg::*;

	// ===================================================================
	// Constants and DUT signals
	// ===================================================================

	localparam int    NUM_SCEN    = 4;
	localparam int    SCEN_FRAMES = NUM_SCEN * 3;
	localparam longint WATCHDOG_NS = longint'(SCEN_FRAMES + 2) * 84480 * 10 * 20;
	localparam center_t H_CEN = 4'd3;
	localparam center_t V_CEN = 4'd2;

	localparam rgb_t BLACK = '0;
	localparam rgb_t RED   = {5'd31, 5'd0, 5'd0};
	localparam rgb_t GREEN = {5'd0, 5'd31, 5'd0};
	localparam rgb_t BLUE  = {5'd0, 5'd0, 5'd31};
	localparam rgb_t GB    = {5'd0, 5'd31, 5'd31};

	logic     clk_49m;
	logic     reset;
	center_t  h_center_i;
	center_t  v_center_i;
	host_wr_t host_wr_i;
	logic     host_valid_i;
	logic     host_ready_o;
	rgb_t     rgb_o;
	logic     hblank_o;
	logic     vblank_o;
	logic     hsync_o;
	logic     vsync_o;
	logic     csync_o;
	logic     ce_pix_o;

	blueprint_sprite_video uut (
		.clk_49m      (clk_49m),
		.reset        (reset),
		.h_center_i   (h_center_i),
		.v_center_i   (v_center_i),
		.host_wr_i    (host_wr_i),
		.host_valid_i (host_valid_i),
		.host_ready_o (host_ready_o),
		.rgb_o        (rgb_o),
		.hblank_o     (hblank_o),
		.vblank_o     (vblank_o),
		.hsync_o      (hsync_o),
		.vsync_o      (vsync_o),
		.csync_o      (csync_o),
		.ce_pix_o     (ce_pix_o)
	);

	// Clock, 20 ns period
	always #10 clk_49m = ~clk_49m;

	// ===================================================================
	// Tables and reference state
	// ===================================================================

	// Host writes per scenario
	int       wr_scen [0:31];
	host_wr_t wr_row  [0:31];
	int       num_wr;
	// Probe pixels with hand-derived colours
	int       pr_scen [0:31];
	int       pr_line [0:31];
	int       pr_col  [0:31];
	rgb_t     pr_rgb  [0:31];
	int       num_pr;

	// Mirror of what the host has written
	byte_t      attr_m [0:255];
	byte_t      pr_m   [0:4095];
	byte_t      pb_m   [0:4095];
	byte_t      pg_m   [0:4095];
	spr_pixel_t line_m [0:255];

	integer seed;
	int     cur_h;
	int     cur_v;
	int     cur_scen;
	int     frame_count;
	int     stall_count;
	int     error_count;
	logic   monitor_on;
	logic   check_en;

	// Expected timing flags of the current pixel
	logic   exp_hblank;
	logic   exp_vblank;
	logic   exp_hsync;
	logic   exp_vsync;

	// Pixel enable cadence tracking
	int     ce_clocks;
	int     ce_pulses;
	logic   ce_prev;

	task automatic add_write(input int s, input store_target_e t, input int a, input int d);
		wr_scen[num_wr] = s;
		wr_row[num_wr]  = {t, 12'(a), 8'(d)};
		num_wr++;
	endtask

	task automatic add_probe(input int s, input int l, input int c, input rgb_t exp);
		pr_scen[num_pr] = s;
		pr_line[num_pr] = l;
		pr_col[num_pr]  = c;
		pr_rgb[num_pr]  = exp;
		num_pr++;
	endtask

	// ===================================================================
	// Compare tasks
	// ===================================================================

	task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
		if (got !== exp) begin
			$display("** Error: %s got %h expected %h at line %0d col %0d",
				name, got, exp, cur_v, cur_h);
			error_count++;
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error: %s got %h expected %h at line %0d col %0d",
				name, got, exp, cur_v, cur_h);
			error_count++;
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("** Error: %s got %h expected %h at line %0d col %0d",
				name, got, exp, cur_v, cur_h);
			error_count++;
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	// ===================================================================
	// Reference model
	// ===================================================================

	// Each set bit lights its channel fully
	function automatic rgb_t expand(input spr_pixel_t p);
		rgb_t c;
		c.red   = p[0] ? 5'd31 : 5'd0;
		c.blue  = p[1] ? 5'd31 : 5'd0;
		c.green = p[2] ? 5'd31 : 5'd0;
		return c;
	endfunction

	// Sprite pixels of one display line, later sprites on top
	task automatic build_line(input int v);
		int         nl;
		int         raw;
		int         row;
		int         bp;
		int         a;
		logic       flipy;
		byte_t      flags;
		spr_pixel_t p;
		for (int c = 0; c < 256; c++)
			line_m[c] = '0;
		nl = v % 256;
		for (int n = 0; n < 64; n++) begin
			raw   = (nl + 512 - 239 + int'(attr_m[4 * n])) % 512;
			flags = attr_m[4 * n + 2];
			// Y-flip rides on the previous sprite
			flipy = attr_m[4 * ((n + 63) % 64) + 2][7];
			if (raw < 16) begin
				row = flipy ? 15 - raw : raw;
				a   = int'(attr_m[4 * n + 1]) * 16 + row;
				for (int i = 0; i < 8; i++) begin
					bp = flags[6] ? i : 7 - i;
					p  = {pg_m[a][bp], pb_m[a][bp], pr_m[a][bp]};
					if (p != '0)
						line_m[(int'(attr_m[4 * n + 3]) + i + 2) % 256] = p;
				end
			end
		end
	endtask

	// ===================================================================
	// Output monitor
	// ===================================================================

	// Outputs after a pixel enable describe the next raster position
	always @(negedge clk_49m) begin
		if (monitor_on && ce_pix_o) begin
			@(posedge clk_49m);
			#1;
			if (cur_h == 0 && cur_v == 0)
				frame_count++;
			if (cur_h == 0)
				build_line(cur_v);
			exp_hblank = cur_h >= `BPV_H_ACTIVE;
			exp_vblank = cur_v < `BPV_V_ACT_START || cur_v >= `BPV_V_ACT_END;
			exp_hsync  = cur_h >= `BPV_HS_BASE + H_CEN &&
				cur_h < `BPV_HS_BASE + H_CEN + `BPV_HS_WIDTH;
			exp_vsync  = cur_v >= `BPV_VS_BASE + V_CEN &&
				cur_v < `BPV_VS_BASE + V_CEN + `BPV_VS_WIDTH;
			check_bit("hblank_o", hblank_o, exp_hblank);
			check_bit("vblank_o", vblank_o, exp_vblank);
			check_bit("hsync_o", hsync_o, exp_hsync);
			check_bit("vsync_o", vsync_o, exp_vsync);
			// Composite sync high when both syncs agree
			check_bit("csync_o", csync_o, exp_hsync == exp_vsync);
			// Scanner owns the memories early in hblank, never mid-line
			if (cur_h == 258)
				check_bit("host_ready_o", host_ready_o, 1'b0);
			if (cur_h == 128)
				check_bit("host_ready_o", host_ready_o, 1'b1);
			if (check_en) begin
				if (exp_hblank || exp_vblank)
					check_rgb("rgb_o", rgb_o, BLACK);
				else
					check_rgb("rgb_o", rgb_o, expand(line_m[cur_h]));
				for (int k = 0; k < num_pr; k++)
					if (pr_scen[k] == cur_scen && pr_line[k] == cur_v && pr_col[k] == cur_h)
						check_rgb("rgb_o probe", rgb_o, pr_rgb[k]);
			end
			cur_h = (cur_h + 1) % `BPV_H_TOTAL;
			if (cur_h == 0)
				cur_v = (cur_v + 1) % `BPV_V_TOTAL;
		end
	end

	// Pixel enable never on two clocks in a row
	// Any window of DEN clocks from a pulse holds NUM pulses
	always @(negedge clk_49m) begin
		if (monitor_on) begin
			if (ce_prev)
				check_bit("ce_pix_o", ce_pix_o, 1'b0);
			if (ce_pix_o || ce_clocks > 0) begin
				ce_pulses = ce_pulses + int'(ce_pix_o);
				ce_clocks++;
			end
			if (ce_clocks == `BPV_CEN_DEN) begin
				check_count("ce_pix_o pulses", ce_pulses, `BPV_CEN_NUM);
				ce_clocks = 0;
				ce_pulses = 0;
			end
			ce_prev = ce_pix_o;
		end
	end

	// ===================================================================
	// Host writes
	// ===================================================================

	// Random gap, then hold until the handshake completes
	task automatic apply_write(input host_wr_t w);
		int   gap;
		logic taken;
		@(posedge clk_49m);
		#2;
		gap = $random(seed) & 3;
		repeat (gap) begin
			@(posedge clk_49m);
			#2;
		end
		host_wr_i    = w;
		host_valid_i = 1'b1;
		do begin
			@(negedge clk_49m);
			taken = host_ready_o;
			if (!taken)
				stall_count++;
			@(posedge clk_49m);
		end while (!taken);
		#2;
		host_valid_i = 1'b0;
		case (w.target)
			SPRITE_RAM: attr_m[w.addr[7:0]] = w.data;
			PLANE_R:    pr_m[w.addr] = w.data;
			PLANE_B:    pb_m[w.addr] = w.data;
			default:    pg_m[w.addr] = w.data;
		endcase
	endtask

	// Parks every sprite off screen and loads codes 1 and 2
	task automatic init_store();
		for (int a = 0; a < 256; a++)
			apply_write({SPRITE_RAM, 12'(a), (a % 4 == 0) ? 8'hFF : 8'h00});
		for (int r = 0; r < 16; r++) begin
			apply_write({PLANE_R, 12'(16 + r), 8'h80});
			apply_write({PLANE_B, 12'(16 + r), 8'h01});
			apply_write({PLANE_G, 12'(16 + r), 8'(r)});
			apply_write({PLANE_R, 12'(32 + r), (r < 8) ? 8'hFF : 8'h00});
			apply_write({PLANE_B, 12'(32 + r), 8'h00});
			apply_write({PLANE_G, 12'(32 + r), 8'h00});
		end
	endtask

	// ===================================================================
	// Stimulus
	// ===================================================================

	initial begin
		int start;
		clk_49m      = 1'b0;
		reset        = 1'b0;
		h_center_i   = H_CEN;
		v_center_i   = V_CEN;
		host_wr_i    = '0;
		host_valid_i = 1'b0;
		seed         = 6319;
		cur_h        = 0;
		cur_v        = 0;
		cur_scen     = 0;
		frame_count  = 0;
		stall_count  = 0;
		error_count  = 0;
		monitor_on   = 1'b0;
		check_en     = 1'b0;
		num_wr       = 0;
		num_pr       = 0;
		ce_clocks    = 0;
		ce_pulses    = 0;
		ce_prev      = 1'b0;

		// Single sprite placement and colour
		add_write(0, SPRITE_RAM, 20, 8'h8B);
		add_write(0, SPRITE_RAM, 21, 1);
		add_write(0, SPRITE_RAM, 22, 0);
		add_write(0, SPRITE_RAM, 23, 40);
		add_probe(0, 100, 42, RED);
		add_probe(0, 100, 43, BLACK);
		add_probe(0, 100, 49, BLUE);
		add_probe(0, 103, 48, GREEN);
		add_probe(0, 103, 49, GB);
		add_probe(0, 99, 42, BLACK);
		// X-flip, carried Y-flip, sprite 0 flipped by sprite 63
		add_write(1, SPRITE_RAM, 18, 8'h80);
		add_write(1, SPRITE_RAM, 22, 8'h40);
		add_write(1, SPRITE_RAM, 254, 8'h80);
		add_write(1, SPRITE_RAM, 0, 8'h8B);
		add_write(1, SPRITE_RAM, 1, 2);
		add_write(1, SPRITE_RAM, 2, 0);
		add_write(1, SPRITE_RAM, 3, 100);
		add_probe(1, 100, 42, GB);
		add_probe(1, 100, 49, RED);
		add_probe(1, 100, 46, BLACK);
		add_probe(1, 100, 102, BLACK);
		add_probe(1, 108, 105, RED);
		// Overlap over sprite 5, empty line below
		add_write(2, SPRITE_RAM, 24, 8'h8B);
		add_write(2, SPRITE_RAM, 25, 1);
		add_write(2, SPRITE_RAM, 26, 0);
		add_write(2, SPRITE_RAM, 27, 41);
		add_probe(2, 100, 43, RED);
		add_probe(2, 100, 42, GB);
		add_probe(2, 100, 50, BLUE);
		add_probe(2, 130, 43, BLACK);
		// Wrap from column 255 into column 0
		add_write(3, SPRITE_RAM, 28, 8'h8B);
		add_write(3, SPRITE_RAM, 29, 2);
		add_write(3, SPRITE_RAM, 30, 0);
		add_write(3, SPRITE_RAM, 31, 253);
		add_probe(3, 104, 255, RED);
		add_probe(3, 104, 0, RED);
		add_probe(3, 104, 6, RED);
		add_probe(3, 104, 7, BLACK);
		add_probe(3, 110, 255, BLACK);

		repeat (5) @(posedge clk_49m);
		#2;
		reset      = 1'b1;
		monitor_on = 1'b1;

		for (int s = 0; s < NUM_SCEN; s++) begin
			cur_scen = s;
			// Start near hblank so writes run into a scan
			wait (cur_h == 250);
			if (s == 0)
				init_store();
			for (int k = 0; k < num_wr; k++)
				if (wr_scen[k] == s)
					apply_write(wr_row[k]);
			start = frame_count;
			wait (frame_count == start + 1);
			check_en = 1'b1;
			wait (frame_count == start + 2);
			check_en = 1'b0;
		end

		if (stall_count == 0) begin
			$display("No host write was ever held off by a scan");
			error_count++;
		end
		if (error_count != 0) begin
			$display("Test failures found");
			$fatal(1);
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

	// Watchdog sized from the number of frames the scenarios take
	initial begin
		#(WATCHDOG_NS);
		$display("Simulation timed out before all scenarios finished");
		$display("Test failures found");
		$fatal(1);
	end

endmodule

`default_nettype wire
